// ==== sources.f ====
+incdir+.
pagerank_pkg.sv
vertex_job_fifo.sv
vertex_sequencer.sv
edge_counter.sv
rank_accumulator.sv
pagerank_vertex_unit.sv
pagerank_assertions.sv
tb_pagerank_vertex_unit.sv

// ==== tb_pagerank_vertex_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for the vertex unit, results against a sum model
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pagerank_cfg.svh"

module tb_pagerank_vertex_unit;
	timeunit 1ns;
	timeprecision 1ps;

	typedef logic [`PR_RANK_W-1:0] contrib_q_t[$];

	logic                      clock = 1'b0;
	logic                      rstn;
	logic                      enabled;
	pagerank_pkg::vertex_job_t vertex_job;
	pagerank_pkg::edge_data_t  edge_data;
	logic                      edge_request;
	logic                      vertex_job_request;
	pagerank_pkg::rank_write_t rank_write;
	logic [`PR_COUNT_W-1:0]    vertex_num_counter;
	logic [`PR_COUNT_W-1:0]    edge_num_counter;

	integer seed = 32'h6bac;
	int     errors = 0;
	int     tests = 0;
	int     failed_tests = 0;
	int     errors_base = 0;
	int     results_seen = 0;
	int     results_expected = 0;
	bit     saw_edge_request = 1'b0;
	string  current_test = "reset";
	pagerank_pkg::rank_write_t expected_q[$];

	pagerank_vertex_unit UUT (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.vertex_job        (vertex_job),
		.edge_data         (edge_data),
		.edge_request      (edge_request),
		.vertex_job_request(vertex_job_request),
		.rank_write        (rank_write),
		.vertex_num_counter(vertex_num_counter),
		.edge_num_counter  (edge_num_counter)
	);

	always #20 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Reference model and compare tasks
	////////////////////////////////////////////////////////////////////////////

	// Plain sum, wrapping at the rank width
	function automatic logic [`PR_RANK_W-1:0] expected_rank(input contrib_q_t contrib);
		logic [`PR_RANK_W-1:0] sum;
		sum = '0;
		foreach (contrib[i])
			sum = sum + contrib[i];
		return sum;
	endfunction

	function automatic contrib_q_t random_contrib(input int n);
		contrib_q_t q;
		repeat (n)
			q.push_back($random(seed));
		return q;
	endfunction

	task automatic check_rank(input pagerank_pkg::rank_write_t expected,
		input pagerank_pkg::rank_write_t actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected vertex %0h rank %0h, actual vertex %0h rank %0h",
				current_test, expected.vertex_id, expected.rank,
				actual.vertex_id, actual.rank);
			errors++;
		end
	endtask

	task automatic check_count(input string item, input logic [`PR_COUNT_W-1:0] expected,
		input logic [`PR_COUNT_W-1:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: %s expected %0d, actual %0d",
				current_test, item, expected, actual);
			errors++;
		end
	endtask

	task automatic check_level(input string item, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAILED %s: %s expected %b, actual %b",
				current_test, item, expected, actual);
			errors++;
		end
	endtask

	// Results come back in queue order
	always @(negedge clock) begin
		if (rstn && edge_request)
			saw_edge_request = 1'b1;
		if (rstn && rank_write.valid) begin
			results_seen++;
			if (expected_q.size() == 0) begin
				$display("ERROR %s: rank write for vertex %0h that was never queued",
					current_test, rank_write.vertex_id);
				errors++;
			end else begin
				check_rank(expected_q.pop_front(), rank_write);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers, all called and returning on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic report_timeout(input string what);
		$display("ERROR %s: timed out after 2000 cycles waiting for %s", current_test, what);
		errors++;
	endtask

	task automatic wait_edge_request();
		int n;
		n = 0;
		while (!edge_request && n < 2000) begin
			@(negedge clock);
			n++;
		end
		if (!edge_request)
			report_timeout("edge_request");
	endtask

	task automatic wait_results();
		int n;
		n = 0;
		while (results_seen < results_expected && n < 2000) begin
			@(negedge clock);
			n++;
		end
		if (results_seen < results_expected)
			report_timeout("rank_write");
	endtask

	task automatic push_job(input logic [`PR_VERTEX_W-1:0] id, input contrib_q_t contrib);
		pagerank_pkg::rank_write_t expected;
		expected = '{valid: 1'b1, vertex_id: id, rank: expected_rank(contrib)};
		expected_q.push_back(expected);
		results_expected++;
		vertex_job = '{valid: 1'b1, vertex_id: id, degree: `PR_DEGREE_W'(contrib.size())};
		@(negedge clock);
		vertex_job.valid = 1'b0;
	endtask

	// Random idle gaps between edges
	task automatic send_edges(input contrib_q_t contrib);
		foreach (contrib[i]) begin
			repeat ($unsigned($random(seed)) % 3)
				@(negedge clock);
			wait_edge_request();
			edge_data = '{valid: 1'b1, value: contrib[i]};
			@(negedge clock);
			edge_data.valid = 1'b0;
		end
	endtask

	task automatic start_test(input string name);
		current_test = name;
		errors_base = errors;
		tests++;
	endtask

	task automatic end_test();
		if (errors == errors_base) begin
			$display("PASS %s", current_test);
		end else begin
			$display("FAIL %s", current_test);
			failed_tests++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		contrib_q_t             vals;
		contrib_q_t             all_vals;
		logic [`PR_COUNT_W-1:0] vertex_base;
		logic [`PR_COUNT_W-1:0] edge_base;
		int                     j;

		rstn = 1'b0;
		enabled = 1'b1;
		vertex_job = '0;
		edge_data = '0;
		repeat (5) @(negedge clock);
		rstn = 1'b1;

		start_test("reset state");
		check_level("vertex_job_request", 1'b1, vertex_job_request);
		check_level("edge_request", 1'b0, edge_request);
		check_count("vertex_num_counter", '0, vertex_num_counter);
		check_count("edge_num_counter", '0, edge_num_counter);
		end_test();

		start_test("single job of degree 4");
		vals = random_contrib(4);
		push_job(16'h0011, vals);
		send_edges(vals);
		wait_results();
		end_test();

		start_test("job of degree 0");
		saw_edge_request = 1'b0;
		vals = {};
		push_job(16'h0022, vals);
		wait_results();
		check_level("edge_request seen", 1'b0, saw_edge_request);
		end_test();

		start_test("five queued jobs");
		vertex_base = vertex_num_counter;
		edge_base = edge_num_counter;
		all_vals = {};
		for (j = 0; j < 5; j++) begin
			vals = random_contrib(1 + $unsigned($random(seed)) % 6);
			push_job(`PR_VERTEX_W'(16'h0100 + j), vals);
			foreach (vals[i])
				all_vals.push_back(vals[i]);
		end
		send_edges(all_vals);
		wait_results();
		check_count("vertices done", 5, vertex_num_counter - vertex_base);
		check_count("edges taken", all_vals.size(), edge_num_counter - edge_base);
		end_test();

		start_test("stray edges and freeze");
		edge_base = edge_num_counter;
		edge_data = '{valid: 1'b1, value: 32'hdead_beef};
		repeat (3) @(negedge clock);
		edge_data.valid = 1'b0;
		check_count("edges taken while idle", edge_base, edge_num_counter);
		vals = random_contrib(3);
		push_job(16'h0033, vals);
		send_edges(vals[0:0]);
		// Freeze mid-vertex with a junk edge on the bus
		vertex_base = vertex_num_counter;
		edge_base = edge_num_counter;
		enabled = 1'b0;
		edge_data = '{valid: 1'b1, value: 32'h1234_5678};
		repeat (6) @(negedge clock);
		edge_data.valid = 1'b0;
		check_count("vertices while frozen", vertex_base, vertex_num_counter);
		check_count("edges while frozen", edge_base, edge_num_counter);
		check_count("rank writes while frozen", results_expected - 1, results_seen);
		enabled = 1'b1;
		send_edges(vals[1:2]);
		wait_results();
		end_test();

		$display("Tests run: %0d, tests failed: %0d, errors: %0d",
			tests, failed_tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pagerank_assertions.sv ====
////////////////////////////////////////////////////////////////////////////
// Interface rules of the vertex unit
// Bound into its top level
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module pagerank_assertions (
	input logic                      clock,
	input logic                      rstn,
	input logic                      enabled,
	input pagerank_pkg::vertex_job_t vertex_job,
	input logic                      edge_request,
	input pagerank_pkg::rank_write_t rank_write,
	input pagerank_pkg::seq_state_t  state,
	input logic                      job_full
);
	timeunit 1ns;
	timeprecision 1ps;

	// Edge phase opens once per vertex, as ACCUM follows LOAD
	edge_request_in_accum: assert property (@(posedge clock) disable iff (!rstn)
		$rose(edge_request) |-> state == pagerank_pkg::ACCUM
			&& $past(state) == pagerank_pkg::LOAD)
		else $error("edge_request raised outside the step from LOAD to ACCUM");

	// One cycle per completed vertex
	rank_write_single_cycle: assert property (@(posedge clock) disable iff (!rstn)
		(rank_write.valid && enabled) |=> !rank_write.valid)
		else $error("rank_write.valid held for two cycles");

	no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
		!(enabled && vertex_job.valid && job_full))
		else $error("vertex job pushed while the queue is full");

endmodule

bind pagerank_vertex_unit pagerank_assertions assertions (.*);

`default_nettype wire

// ==== pagerank_vertex_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// PageRank vertex unit top: job queue, FSM, edge counter and accumulator
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pagerank_cfg.svh"

module pagerank_vertex_unit (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  pagerank_pkg::vertex_job_t vertex_job,
	input  pagerank_pkg::edge_data_t  edge_data,
	output logic                      edge_request,
	output logic                      vertex_job_request,
	output pagerank_pkg::rank_write_t rank_write,
	output logic [`PR_COUNT_W-1:0]    vertex_num_counter,
	output logic [`PR_COUNT_W-1:0]    edge_num_counter
);

	pagerank_pkg::vertex_job_t  head_job;
	pagerank_pkg::seq_state_t   state;
	logic                       job_empty;
	logic                       job_full;
	logic                       pop;
	logic                       start;
	logic                       accumulate;
	logic                       write_rank;
	logic                       degree_reached;
	logic                       edge_taken;

	// Contribution counts only while the FSM asks for edges
	assign edge_taken         = accumulate && edge_data.valid;
	assign edge_request       = accumulate;
	assign vertex_job_request = job_empty;

	vertex_job_fifo job_fifo (
		.clock  (clock),
		.rstn   (rstn),
		.enabled(enabled),
		.job_in (vertex_job),
		.pop    (pop),
		.job_out(head_job),
		.empty  (job_empty),
		.full   (job_full)
	);

	vertex_sequencer sequencer (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.empty         (job_empty),
		.degree_reached(degree_reached),
		.pop           (pop),
		.start         (start),
		.accumulate    (accumulate),
		.write_rank    (write_rank),
		.state         (state)
	);

	edge_counter counter (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.start         (start),
		.degree        (head_job.degree),
		.edge_taken    (edge_taken),
		.degree_reached(degree_reached)
	);

	rank_accumulator accumulator (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.start             (start),
		.job               (head_job),
		.edge_taken        (edge_taken),
		.value             (edge_data.value),
		.write_rank        (write_rank),
		.rank_write        (rank_write),
		.vertex_num_counter(vertex_num_counter),
		.edge_num_counter  (edge_num_counter)
	);

endmodule

`default_nettype wire

// ==== rank_accumulator.sv ====
////////////////////////////////////////////////////////////////////////////
// Rank sum of one vertex, the registered rank write and running counters
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pagerank_cfg.svh"

module rank_accumulator (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  logic                      start,
	input  pagerank_pkg::vertex_job_t job,
	input  logic                      edge_taken,
	input  logic [`PR_RANK_W-1:0]     value,
	input  logic                      write_rank,
	output pagerank_pkg::rank_write_t rank_write,
	output logic [`PR_COUNT_W-1:0]    vertex_num_counter,
	output logic [`PR_COUNT_W-1:0]    edge_num_counter
);

	logic [`PR_VERTEX_W-1:0] vertex_id_q;
	logic [`PR_RANK_W-1:0]   rank_sum;
	logic                    rank_valid;
	logic [`PR_VERTEX_W-1:0] rank_vertex_id;
	logic [`PR_RANK_W-1:0]   rank_value;

	// Sum wraps at the rank width
	always_ff @(posedge clock) begin
		if (enabled) begin
			if (start) begin
				vertex_id_q <= job.vertex_id;
				rank_sum    <= '0;
			end else if (edge_taken) begin
				rank_sum <= rank_sum + value;
			end
			if (write_rank) begin
				rank_vertex_id <= vertex_id_q;
				rank_value     <= rank_sum;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			rank_valid         <= 1'b0;
			vertex_num_counter <= '0;
			edge_num_counter   <= '0;
		end else if (enabled) begin
			rank_valid <= write_rank;
			if (write_rank)
				vertex_num_counter <= vertex_num_counter + 1'b1;
			if (edge_taken)
				edge_num_counter <= edge_num_counter + 1'b1;
		end
	end

	assign rank_write = '{valid: rank_valid, vertex_id: rank_vertex_id, rank: rank_value};

endmodule

`default_nettype wire

// ==== edge_counter.sv ====
////////////////////////////////////////////////////////////////////////////
// Counts accepted edges of the current vertex against its degree
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pagerank_cfg.svh"

module edge_counter (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  logic                    start,
	input  logic [`PR_DEGREE_W-1:0] degree,
	input  logic                    edge_taken,
	output logic                    degree_reached
);

	logic [`PR_DEGREE_W-1:0] degree_q;
	logic [`PR_DEGREE_W-1:0] count;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			degree_q <= '0;
			count    <= '0;
		end else if (enabled) begin
			if (start) begin
				degree_q <= degree;
				count    <= '0;
			end else if (edge_taken) begin
				count <= count + 1'b1;
			end
		end
	end

	// During start the latched degree is stale, so look at the incoming one
	assign degree_reached = start ? (degree == '0) : (count == degree_q);

endmodule

`default_nettype wire

// ==== vertex_sequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// Vertex FSM: takes the head job, runs its edges, then triggers the write
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pagerank_cfg.svh"

module vertex_sequencer (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enabled,
	input  logic                     empty,
	input  logic                     degree_reached,
	output logic                     pop,
	output logic                     start,
	output logic                     accumulate,
	output logic                     write_rank,
	output pagerank_pkg::seq_state_t state
);

	pagerank_pkg::seq_state_t next_state;

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			pagerank_pkg::IDLE: begin
				if (!empty)
					next_state = pagerank_pkg::LOAD;
			end
			pagerank_pkg::LOAD: begin
				// Degree of zero skips the edge phase
				if (degree_reached)
					next_state = pagerank_pkg::WRITE;
				else
					next_state = pagerank_pkg::ACCUM;
			end
			pagerank_pkg::ACCUM: begin
				if (degree_reached)
					next_state = pagerank_pkg::WRITE;
			end
			pagerank_pkg::WRITE: begin
				next_state = pagerank_pkg::IDLE;
			end
			default: begin
				next_state = pagerank_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			state <= pagerank_pkg::IDLE;
		end else if (enabled) begin
			state <= next_state;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Decoded controls
	////////////////////////////////////////////////////////////////////////////

	// Head leaves the queue at the end of LOAD, as it is captured
	assign pop        = (state == pagerank_pkg::LOAD);
	assign start      = (state == pagerank_pkg::LOAD);

	// No edge taken once the count has met the degree
	assign accumulate = (state == pagerank_pkg::ACCUM) && !degree_reached;
	assign write_rank = (state == pagerank_pkg::WRITE);

endmodule

`default_nettype wire

// ==== vertex_job_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// Circular queue of vertex jobs, pushed on the valid bit of the job
// Head entry is visible without a pop; a push while full is lost
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pagerank_cfg.svh"

module vertex_job_fifo (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  pagerank_pkg::vertex_job_t job_in,
	input  logic                      pop,
	output pagerank_pkg::vertex_job_t job_out,
	output logic                      empty,
	output logic                      full
);

	localparam int PTR_W = $clog2(`PR_JOB_DEPTH);

	pagerank_pkg::vertex_job_t mem [`PR_JOB_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             push_ok;
	logic             pop_ok;

	assign push_ok = enabled && job_in.valid && !full;
	assign pop_ok  = enabled && pop && !empty;

	assign empty   = (count == '0);
	assign full    = (count == (PTR_W + 1)'(`PR_JOB_DEPTH));
	assign job_out = mem[rd_ptr];

	// Storage
	always_ff @(posedge clock) begin
		if (push_ok) begin
			mem[wr_ptr] <= job_in;
		end
	end

	// Pointers wrap at the last entry
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				if (wr_ptr == PTR_W'(`PR_JOB_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				if (rd_ptr == PTR_W'(`PR_JOB_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== pagerank_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Types shared by the vertex unit RTL and its testbench
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pagerank_cfg.svh"

package pagerank_pkg;

	// Job pushed into the queue, one per vertex
	typedef struct packed {
		logic                      valid;
		logic [`PR_VERTEX_W-1:0]   vertex_id;
		logic [`PR_DEGREE_W-1:0]   degree;
	} vertex_job_t;

	// One contribution from an incoming edge
	typedef struct packed {
		logic                      valid;
		logic [`PR_RANK_W-1:0]     value;
	} edge_data_t;

	// Result of one vertex
	typedef struct packed {
		logic                      valid;
		logic [`PR_VERTEX_W-1:0]   vertex_id;
		logic [`PR_RANK_W-1:0]     rank;
	} rank_write_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		ACCUM,
		WRITE
	} seq_state_t;

endpackage

`default_nettype wire

// ==== pagerank_cfg.svh ====
////////////////////////////////////////////////////////////////////////////
// Fixed sizes for the PageRank vertex unit
// Include before any port or type that needs a width
////////////////////////////////////////////////////////////////////////////

`ifndef PAGERANK_CFG_SVH
`define PAGERANK_CFG_SVH

// Field widths
`define PR_VERTEX_W 16
`define PR_DEGREE_W 16
`define PR_RANK_W   32

// Completed vertex and accepted edge counters
`define PR_COUNT_W  32

// Vertex job queue entries
`define PR_JOB_DEPTH 8

`endif
